//--- hdl/csi_rx_pkg.sv
/* shared types for the single-lane csi-2 receiver
   lane bytes are lsb first on the wire, so bit 0 of a byte is the oldest bit */
package csi_rx_pkg;

   //--------------------------------------------------
   // widths that carry a meaning
   //--------------------------------------------------
   typedef logic [7:0]  byte_t;        // one lane byte, bit 0 received first
   typedef logic [15:0] word_count_t;  // packet length in bytes

   // leader-to-data marker sent at the start of every hs burst
   localparam byte_t SYNC_BYTE = 8'hB8;

   //--------------------------------------------------
   // streams between the stages
   //--------------------------------------------------
   // deserializer -> aligner, arbitrary bit alignment
   typedef struct packed {
      logic  valid;    // one-cycle strobe per 8 bits
      logic  restart;  // first byte of a new burst
      byte_t data;
   } raw_byte_t;

   // aligner -> parser, byte aligned to the sync
   typedef struct packed {
      logic  valid;
      logic  first;    // first byte after the sync, i.e. the data id
      byte_t data;
   } lane_byte_t;

   // short/long packet header as it leaves the lane
   typedef struct packed {
      byte_t       data_id;
      word_count_t word_count;
      byte_t       ecc;        // captured only, never checked
   } packet_header_t;

   typedef struct packed {
      logic  valid;
      logic  last;     // final byte of the word count
      byte_t data;
   } payload_byte_t;

   //--------------------------------------------------
   // state machines
   //--------------------------------------------------
   typedef enum logic {align_hunt, align_locked} align_state_t;
   typedef enum logic [1:0] {parse_idle, parse_header, parse_payload} parse_state_t;

endpackage

//--- hdl/csi_rx_lane_deser.sv
`timescale 1ns/1ps
/* serial to byte conversion for one hs lane, one bit per bit_clock edge
   byte boundaries are arbitrary; a partial byte at the end of a burst is dropped */
module csi_rx_lane_deser #(
   parameter bit INVERT = 1'b0  // 1 when the p/n pair is swapped on the board
)(
   input  logic                  bit_clock,
   input  logic                  reset,
   input  logic                  lane_bit,   // hs lane bit, sampled every rising edge
   input  logic                  hs_active,  // level, high for the whole burst
   output csi_rx_pkg::raw_byte_t raw
);
   import csi_rx_pkg::*;

   logic       bit_in;      // lane bit after polarity fix
   byte_t      shift_q;     // newest bit lands in bit 7
   byte_t      shift_next;
   logic [2:0] bit_cnt;     // bits taken in the current group
   logic       armed;       // next byte is the first of a burst
   logic       valid_q;
   logic       restart_q;
   byte_t      data_q;

   assign bit_in     = INVERT ? ~lane_bit : lane_bit;  // undo a swapped pair
   assign shift_next = {bit_in, shift_q[7:1]};         // lsb-first packing

   //--------------------------------------------------
   // bit counter, byte strobe and restart mark
   //--------------------------------------------------
   always_ff @(posedge bit_clock) begin
      if (reset) begin
         bit_cnt   <= '0;
         armed     <= 1'b1;  // first burst after reset is a restart too
         valid_q   <= 1'b0;
         restart_q <= 1'b0;
      end else begin
         valid_q   <= 1'b0;  // strobes last one cycle
         restart_q <= 1'b0;
         if (!hs_active) begin
            bit_cnt <= '0;   // hold group start while the lane is idle
            armed   <= 1'b1;
         end else begin
            bit_cnt <= bit_cnt + 3'd1;  // wraps after the eighth bit
            if (bit_cnt == 3'd7) begin
               valid_q   <= 1'b1;
               restart_q <= armed;      // only on the first byte after the rise
               armed     <= 1'b0;
            end
         end
      end
   end

   // shift register and byte capture
   always_ff @(posedge bit_clock) begin
      if (hs_active) shift_q <= shift_next;
      if (hs_active && bit_cnt == 3'd7) data_q <= shift_next;  // complete byte
   end

   always_comb begin
      raw.valid   = valid_q;
      raw.restart = restart_q;
      raw.data    = data_q;
   end

endmodule

//--- hdl/csi_rx_byte_align.sv
`timescale 1ns/1ps
/* finds the 0xb8 sync at any of the 8 bit offsets and locks for the burst
   the lock only clears on the next restart; no re-hunt inside a burst */
module csi_rx_byte_align (
   input  logic                   bit_clock,
   input  logic                   reset,
   input  csi_rx_pkg::raw_byte_t  raw,
   output csi_rx_pkg::lane_byte_t aligned
);
   import csi_rx_pkg::*;

   align_state_t state;
   byte_t        prev_q;      // raw byte of the previous strobe
   logic [2:0]   offset_q;    // bit offset of the sync inside the window
   logic         first_q;     // next emitted byte follows the sync
   logic [15:0]  window;      // two raw bytes, older in the low half
   logic         hit;
   logic [2:0]   hit_offset;
   logic         valid_q;
   logic         first_out_q;
   byte_t        data_q;

   assign window = {raw.data, prev_q};

   //--------------------------------------------------
   // sync search over all offsets
   //--------------------------------------------------
   // scan high to low so the lowest matching offset is kept
   always_comb begin
      hit        = 1'b0;
      hit_offset = '0;
      for (int k = 7; k >= 0; k--) begin
         if (window[k +: 8] == SYNC_BYTE) begin
            hit        = 1'b1;
            hit_offset = 3'(k);
         end
      end
   end

   //--------------------------------------------------
   // hunt / lock control
   //--------------------------------------------------
   always_ff @(posedge bit_clock) begin
      if (reset) begin
         state       <= align_hunt;
         offset_q    <= '0;
         first_q     <= 1'b0;
         valid_q     <= 1'b0;
         first_out_q <= 1'b0;
      end else begin
         valid_q     <= 1'b0;
         first_out_q <= 1'b0;
         if (raw.valid) begin
            if (raw.restart) begin
               // prev_q is stale from the last burst, so skip the search here
               state   <= align_hunt;
               first_q <= 1'b0;
            end else if (state == align_hunt) begin
               if (hit) begin
                  state    <= align_locked;
                  offset_q <= hit_offset;  // sync byte itself is not passed on
                  first_q  <= 1'b1;
               end
            end else begin
               valid_q     <= 1'b1;        // one aligned byte per raw byte
               first_out_q <= first_q;
               first_q     <= 1'b0;
            end
         end
      end
   end

   // data path: history byte and realigned output byte
   always_ff @(posedge bit_clock) begin
      if (raw.valid) prev_q <= raw.data;
      if (raw.valid && state == align_locked) begin
         data_q <= window[offset_q +: 8];  // same offset for the whole burst
      end
   end

   always_comb begin
      aligned.valid = valid_q;
      aligned.first = first_out_q;
      aligned.data  = data_q;
   end

endmodule

//--- hdl/csi_rx_packet_header.sv
`timescale 1ns/1ps
/* csi-2 packet header capture and payload gating for one lane
   ecc is captured as sent and not checked; payload is not buffered */
module csi_rx_packet_header (
   input  logic                      bit_clock,
   input  logic                      reset,
   input  csi_rx_pkg::lane_byte_t    aligned,
   output csi_rx_pkg::packet_header_t header,        // holds until the next header
   output logic                      header_valid,  // one-cycle pulse
   output csi_rx_pkg::payload_byte_t payload
);
   import csi_rx_pkg::*;

   parse_state_t   state;
   logic [1:0]     hdr_idx;     // header byte expected next, 1..3
   word_count_t    remaining;   // payload bytes still to pass on
   byte_t          data_id_q;   // staging so header stays stable during capture
   word_count_t    wc_q;
   logic           take_first;
   logic           take_hdr;
   logic           take_ecc;
   logic           take_pay;
   logic           pay_valid;
   logic           pay_last;
   byte_t          pay_data;

   //--------------------------------------------------
   // byte classification
   //--------------------------------------------------
   assign take_first = aligned.valid && aligned.first;  // wins in any state
   assign take_hdr   = aligned.valid && !aligned.first && state == parse_header;
   assign take_ecc   = take_hdr && hdr_idx == 2'd3;
   assign take_pay   = aligned.valid && !aligned.first && state == parse_payload;

   //--------------------------------------------------
   // parser FSM
   //--------------------------------------------------
   always_ff @(posedge bit_clock) begin
      if (reset) begin
         state        <= parse_idle;
         hdr_idx      <= '0;
         remaining    <= '0;
         header_valid <= 1'b0;
         pay_valid    <= 1'b0;
         pay_last     <= 1'b0;
      end else begin
         header_valid <= 1'b0;
         pay_valid    <= 1'b0;
         pay_last     <= 1'b0;
         if (take_first) begin
            state   <= parse_header;  // restart capture, even mid-payload
            hdr_idx <= 2'd1;
         end else if (take_hdr) begin
            hdr_idx <= hdr_idx + 2'd1;
            if (take_ecc) begin
               header_valid <= 1'b1;
               remaining    <= wc_q;
               // zero length goes straight back to idle
               state <= (wc_q == '0) ? parse_idle : parse_payload;
            end
         end else if (take_pay) begin
            pay_valid <= 1'b1;
            pay_last  <= (remaining == 16'd1);
            remaining <= remaining - 16'd1;
            if (remaining == 16'd1) state <= parse_idle;  // rest of burst ignored
         end
      end
   end

   //--------------------------------------------------
   // header fields and payload byte
   //--------------------------------------------------
   always_ff @(posedge bit_clock) begin
      if (take_first) data_id_q <= aligned.data;
      if (take_hdr && hdr_idx == 2'd1) wc_q[7:0]  <= aligned.data;  // wc low
      if (take_hdr && hdr_idx == 2'd2) wc_q[15:8] <= aligned.data;  // wc high
      if (take_ecc) header <= {data_id_q, wc_q, aligned.data};
      if (take_pay) pay_data <= aligned.data;
   end

   always_comb begin
      payload.valid = pay_valid;
      payload.last  = pay_last;
      payload.data  = pay_data;
   end

endmodule

//--- hdl/csi_rx_lane.sv
`timescale 1ns/1ps
/* one csi-2 receive lane in the bit clock domain, no back-pressure
   header_valid and payload.valid are single-cycle pulses the consumer must take */
module csi_rx_lane #(
   parameter bit INVERT = 1'b0  // set when the lane pair is swapped
)(
   input  logic                      bit_clock,
   input  logic                      reset,
   input  logic                      lane_bit,
   input  logic                      hs_active,
   output csi_rx_pkg::packet_header_t header,
   output logic                      header_valid,
   output csi_rx_pkg::payload_byte_t payload
);
   import csi_rx_pkg::*;

   raw_byte_t  raw;      // unaligned bytes
   lane_byte_t aligned;  // bytes after the sync

   //--------------------------------------------------
   // serial in -> raw bytes -> aligned bytes -> packets
   //--------------------------------------------------
   csi_rx_lane_deser #(
      .INVERT    (INVERT)
   ) u_deser (
      .bit_clock (bit_clock),
      .reset     (reset),
      .lane_bit  (lane_bit),
      .hs_active (hs_active),
      .raw       (raw)
   );

   csi_rx_byte_align u_align (
      .bit_clock (bit_clock),
      .reset     (reset),
      .raw       (raw),
      .aligned   (aligned)
   );

   csi_rx_packet_header u_parse (
      .bit_clock    (bit_clock),
      .reset        (reset),
      .aligned      (aligned),
      .header       (header),
      .header_valid (header_valid),
      .payload      (payload)
   );

endmodule

//--- tests/csi_rx_lane_sva.sv
`timescale 1ns/1ps
/* assertions bound into csi_rx_lane
   strobe exclusivity, and no payload before the first header after reset */
module csi_rx_lane_sva (
   input logic                      bit_clock,
   input logic                      reset,
   input logic                      header_valid,
   input csi_rx_pkg::payload_byte_t payload
);

   logic seen_header;  // a header went out since reset

   always_ff @(posedge bit_clock) begin
      if (reset) seen_header <= 1'b0;
      else if (header_valid) seen_header <= 1'b1;
   end

   //--------------------------------------------------
   // output strobe rules
   //--------------------------------------------------
   payload_after_header: assert property (
      @(posedge bit_clock) disable iff (reset) payload.valid |-> seen_header
   ) else $error("payload.valid before the first header_valid");

   last_with_valid: assert property (
      @(posedge bit_clock) disable iff (reset) payload.last |-> payload.valid
   ) else $error("payload.last without payload.valid");

   strobes_exclusive: assert property (
      @(posedge bit_clock) disable iff (reset) !(header_valid && payload.valid)
   ) else $error("header_valid and payload.valid in the same cycle");

endmodule

//--- tests/tb_csi_rx_lane.sv
`timescale 1ns/1ps
/* random burst testbench for one csi-2 lane, DUT built with INVERT = 1
   one packet per burst; a flush byte follows the data since the aligner runs a byte late */
module tb_csi_rx_lane;
   import csi_rx_pkg::*;

   localparam int NUM_BURSTS     = 40;
   localparam int MAX_BURST_BITS = 16 + 23 + 8 + 32 + 40 * 8 + 8 + 7;  // idle .. trailer
   localparam int WATCHDOG_NS    = (3 + NUM_BURSTS * MAX_BURST_BITS + 200) * 8;

   logic           bit_clock;
   logic           reset;
   logic           lane_bit;
   logic           hs_active;
   packet_header_t header;
   logic           header_valid;
   payload_byte_t  payload;

   logic [31:0]    lfsr_state;
   packet_header_t exp_header[$];   // headers in send order
   byte_t          exp_payload[$];  // payload bytes of all packets, in order
   int             pay_left;        // bytes still due after the last header
   int             headers_seen;
   int             errors;

   csi_rx_lane #(
      .INVERT       (1'b1)
   ) u_csi_rx_lane (
      .bit_clock    (bit_clock),
      .reset        (reset),
      .lane_bit     (lane_bit),
      .hs_active    (hs_active),
      .header       (header),
      .header_valid (header_valid),
      .payload      (payload)
   );

   bind csi_rx_lane csi_rx_lane_sva u_sva (
      .bit_clock    (bit_clock),
      .reset        (reset),
      .header_valid (header_valid),
      .payload      (payload)
   );

   initial begin
      bit_clock = 1'b0;
      forever #4 bit_clock = ~bit_clock;  // 8 ns bit period
   end

   //--------------------------------------------------
   // checking
   //--------------------------------------------------
   task automatic abort_run(input string reason);
      errors++;
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic expect_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t",
                  name, actual, expected, $time);
         abort_run("value check failed");
      end
   endtask

   // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit taken
   function automatic logic [31:0] draw_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value      = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      end
      return value;
   endfunction

   //--------------------------------------------------
   // lane driver
   //--------------------------------------------------
   task automatic send_bit(input logic b);
      @(negedge bit_clock);
      hs_active = 1'b1;
      lane_bit  = ~b;  // pair swapped on the board
   endtask

   task automatic send_byte(input byte_t b);
      for (int i = 0; i < 8; i++) send_bit(b[i]);  // lsb first
   endtask

   task automatic send_burst(input int index);
      int             idle;
      int             leader;
      int             trailer;
      packet_header_t hdr;
      byte_t          data;
      idle           = draw_bits(4);
      leader         = draw_bits(5) % 24;
      hdr.data_id    = 8'(draw_bits(8));
      hdr.word_count = 16'(draw_bits(6) % 41);
      hdr.ecc        = 8'(draw_bits(8));
      if (index < 24) leader = index;             // walk every leader length once
      if (index % 10 == 3) hdr.word_count = '0;   // force some zero-length packets
      exp_header.push_back(hdr);
      repeat (idle + 1) begin                     // at least one low cycle, so a restart
         @(negedge bit_clock);
         hs_active = 1'b0;
         lane_bit  = 1'b0;
      end
      repeat (leader) send_bit(1'b0);             // shifts the bit offset
      send_byte(SYNC_BYTE);
      send_byte(hdr.data_id);
      send_byte(hdr.word_count[7:0]);
      send_byte(hdr.word_count[15:8]);
      send_byte(hdr.ecc);
      repeat (hdr.word_count) begin
         data = 8'(draw_bits(8));
         exp_payload.push_back(data);
         send_byte(data);
      end
      send_byte(8'h00);                           // flush byte, pushes the last byte out
      trailer = draw_bits(3);
      repeat (trailer) send_bit(1'(draw_bits(1)));
   endtask

   //--------------------------------------------------
   // output monitor, samples mid-cycle
   //--------------------------------------------------
   always @(negedge bit_clock) begin
      if (header_valid === 1'b1) begin
         if (exp_header.size() == 0) begin
            abort_run("header_valid pulsed with no packet outstanding");
         end else begin
            expect_equal("payload count", pay_left, 0);  // previous packet complete
            expect_equal("header.data_id", header.data_id, exp_header[0].data_id);
            expect_equal("header.word_count", header.word_count, exp_header[0].word_count);
            expect_equal("header.ecc", header.ecc, exp_header[0].ecc);
            pay_left = exp_header[0].word_count;
            void'(exp_header.pop_front());
            headers_seen++;
         end
      end
      if (payload.valid === 1'b1) begin
         if (pay_left == 0) begin
            abort_run("payload byte outside any packet");
         end else begin
            expect_equal("payload.data", payload.data, exp_payload.pop_front());
            expect_equal("payload.last", payload.last, pay_left == 1);
            pay_left--;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run("timeout, the bursts did not drain in the expected time");
   end

   initial begin
      lfsr_state   = 32'h9bb8;
      reset        = 1'b1;
      lane_bit     = 1'b0;
      hs_active    = 1'b0;
      pay_left     = 0;
      headers_seen = 0;
      errors       = 0;
      repeat (3) begin                            // outputs quiet while in reset
         @(negedge bit_clock);
         expect_equal("header_valid", header_valid, 0);
         expect_equal("payload.valid", payload.valid, 0);
      end
      reset = 1'b0;
      for (int b = 0; b < NUM_BURSTS; b++) send_burst(b);
      @(negedge bit_clock);
      hs_active = 1'b0;
      while (exp_header.size() != 0 || pay_left != 0) @(negedge bit_clock);
      repeat (32) @(negedge bit_clock);           // no stray strobes afterwards
      expect_equal("header count", headers_seen, NUM_BURSTS);
      expect_equal("leftover payload", exp_payload.size(), 0);
      if (errors == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         abort_run("errors were counted during the run");
      end
   end

endmodule

//--- sources.f
hdl/csi_rx_pkg.sv
hdl/csi_rx_lane_deser.sv
hdl/csi_rx_byte_align.sv
hdl/csi_rx_packet_header.sv
hdl/csi_rx_lane.sv
tests/csi_rx_lane_sva.sv
tests/tb_csi_rx_lane.sv
